/* eboxVmaTop.sv */
`timescale 1ns/1ns
`default_nettype none

module eboxVmaTop import klWordPkg::*, klCtlPkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic     clk,
  input  wire logic     arstN,
  input  wire logic     uStrobe,
  input  wire uWord_t   uWord,
  input  wire adWord_u  ad,
  input  wire logic     diagStrobe,
  input  wire diagSel_e diagSel,
  output vmaAddr_t      vmaOut,
  output vmaAddr_t      pcOut,
  output logic          brkMatch,
  output logic          diagValid,
  output ebusWord_t     diagData,
  output logic          acRdValid,
  output ebusWord_t     acRdData,
  output logic          memReq,
  output vmaAddr_t      memAddr,
  output logic          memWrite,
  output ebusWord_t     memData,
  output logic          fifoOverflow
);

  logic       ctlStrobe;
  vmaSrc_e    vmaSrc;
  vmaxSel_e   vmaxSel;
  logic [7:0] magic;
  logic       memRead;
  logic       memWriteCtl;
  logic       loadPc;
  logic       loadHeld;
  logic       loadBreak;
  logic       loadPrevCtx;
  logic       refStrobe;
  logic       refAcRef;
  logic       refWrite;
  vmaAddr_t   refAddr;
  ebusWord_t  refData;
  logic       popValid;
  logic       popAck;
  logic       headAcRef;
  logic       headWrite;
  vmaAddr_t   headAddr;
  ebusWord_t  headData;

  microDecode u_microDecode (
    .clk(clk), .arstN(arstN), .uStrobe(uStrobe), .uWord(uWord),
    .ctlStrobe(ctlStrobe), .vmaSrc(vmaSrc), .vmaxSel(vmaxSel), .magic(magic),
    .memRead(memRead), .memWrite(memWriteCtl), .loadPc(loadPc), .loadHeld(loadHeld),
    .loadBreak(loadBreak), .loadPrevCtx(loadPrevCtx)
  );

  vma u_vma (
    .clk(clk), .arstN(arstN), .ctlStrobe(ctlStrobe), .vmaSrc(vmaSrc),
    .vmaxSel(vmaxSel), .magic(magic), .memRead(memRead), .memWrite(memWriteCtl),
    .loadPc(loadPc), .loadHeld(loadHeld), .loadBreak(loadBreak),
    .loadPrevCtx(loadPrevCtx), .ad(ad), .diagStrobe(diagStrobe), .diagSel(diagSel),
    .vmaOut(vmaOut), .pcOut(pcOut), .brkMatch(brkMatch), .refStrobe(refStrobe),
    .refAcRef(refAcRef), .refWrite(refWrite), .refAddr(refAddr), .refData(refData),
    .diagValid(diagValid), .diagData(diagData)
  );

  memRefFifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_memRefFifo (
    .clk(clk), .arstN(arstN), .refStrobe(refStrobe), .refAcRef(refAcRef),
    .refWrite(refWrite), .refAddr(refAddr), .refData(refData), .popAck(popAck),
    .popValid(popValid), .headAcRef(headAcRef), .headWrite(headWrite),
    .headAddr(headAddr), .headData(headData), .overflow(fifoOverflow)
  );

  memRefDispatch u_memRefDispatch (
    .clk(clk), .arstN(arstN), .popValid(popValid), .headAcRef(headAcRef),
    .headWrite(headWrite), .headAddr(headAddr), .headData(headData), .popAck(popAck),
    .acRdValid(acRdValid), .acRdData(acRdData), .memReq(memReq), .memAddr(memAddr),
    .memWrite(memWrite), .memData(memData)
  );

endmodule

`default_nettype wire

/* flist.f */
+incdir+.
klWordPkg.sv
klCtlPkg.sv
microDecode.sv
vma.sv
memRefFifo.sv
memRefDispatch.sv
eboxVmaTop.sv
tbEboxVma.sv

/* klCtlPkg.sv */
`default_nettype none

package klCtlPkg;

  // Next offset source
  typedef enum logic [1:0] {
    SRC_KEEP     = 2'd0,
    SRC_AD       = 2'd1,
    SRC_PC_MAGIC = 2'd2,
    SRC_INC      = 2'd3
  } vmaSrc_e;

  // Next section source
  typedef enum logic [1:0] {
    SEC_KEEP = 2'd0,
    SEC_PC   = 2'd1,
    SEC_PREV = 2'd2,
    SEC_AD   = 2'd3
  } vmaxSel_e;

  typedef enum logic [1:0] {
    DIAG_PC    = 2'd0,
    DIAG_HELD  = 2'd1,
    DIAG_BREAK = 2'd2,
    DIAG_VMA   = 2'd3
  } diagSel_e;

  // Microword, bits 5..0 are spare
  typedef logic [23:0] uWord_t;

  localparam int UW_SRC_LSB    = 22;
  localparam int UW_VMAX_LSB   = 20;
  localparam int UW_MAGIC_LSB  = 12;
  localparam int UW_MEM_READ   = 11;
  localparam int UW_MEM_WRITE  = 10;
  localparam int UW_LOAD_PC    = 9;
  localparam int UW_LOAD_HELD  = 8;
  localparam int UW_LOAD_BREAK = 7;
  localparam int UW_LOAD_PREV  = 6;

endpackage

`default_nettype wire

/* klWordPkg.sv */
`default_nettype none

package klWordPkg;

  // Machine word, bit 0 is the MSB
  typedef logic [0:35] ebusWord_t;

  // Virtual address keeps the word bit numbers
  // Section is bits 13..17 and offset is bits 18..35
  typedef logic [13:35] vmaAddr_t;

  // Fast AC file size
  localparam int AC_COUNT = 16;

  // AD bus word, seen as raw data or as address fields
  typedef union packed {
    ebusWord_t raw;
    struct packed {
      logic [0:12]  flags;
      logic [13:17] section;
      logic [18:35] offset;
    } addr;
  } adWord_u;

endpackage

`default_nettype wire

/* memRefDispatch.sv */
`timescale 1ns/1ns
`default_nettype none

module memRefDispatch import klWordPkg::*; (
  input  wire logic      clk,
  input  wire logic      arstN,
  input  wire logic      popValid,
  input  wire logic      headAcRef,
  input  wire logic      headWrite,
  input  wire vmaAddr_t  headAddr,
  input  wire ebusWord_t headData,
  output logic           popAck,
  output logic           acRdValid,
  output ebusWord_t      acRdData,
  output logic           memReq,
  output vmaAddr_t       memAddr,
  output logic           memWrite,
  output ebusWord_t      memData
);

  localparam int AC_IDX_W = $clog2(AC_COUNT);

  ebusWord_t           acFile [AC_COUNT];
  logic [AC_IDX_W-1:0] acIdx;
  logic                acHit;
  logic                memHit;

  // Head is taken the cycle it shows up
  assign popAck = popValid;

  // AC number is the low offset bits
  assign acIdx  = headAddr[36-AC_IDX_W:35];
  assign acHit  = popValid & headAcRef;
  assign memHit = popValid & ~headAcRef;

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      acRdValid <= 1'b0;
      memReq    <= 1'b0;
      memWrite  <= 1'b0;
    end else begin
      acRdValid <= acHit & ~headWrite;
      memReq    <= memHit;
      if (memHit) begin
        memWrite <= headWrite;
      end
    end
  end

  // Fast AC file
  always_ff @(posedge clk) begin
    if (acHit && headWrite) begin
      acFile[acIdx] <= headData;
    end
    if (acHit && !headWrite) begin
      acRdData <= acFile[acIdx];
    end
  end

  // External memory port
  always_ff @(posedge clk) begin
    if (memHit) begin
      memAddr <= headAddr;
      memData <= headData;
    end
  end

endmodule

`default_nettype wire

/* memRefFifo.sv */
`timescale 1ns/1ns
`default_nettype none

module memRefFifo import klWordPkg::*; #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic      clk,
  input  wire logic      arstN,
  input  wire logic      refStrobe,
  input  wire logic      refAcRef,
  input  wire logic      refWrite,
  input  wire vmaAddr_t  refAddr,
  input  wire ebusWord_t refData,
  input  wire logic      popAck,
  output logic           popValid,
  output logic           headAcRef,
  output logic           headWrite,
  output vmaAddr_t       headAddr,
  output ebusWord_t      headData,
  output logic           overflow
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  logic             acRefMem [FIFO_DEPTH];
  logic             writeMem [FIFO_DEPTH];
  vmaAddr_t         addrMem  [FIFO_DEPTH];
  ebusWord_t        dataMem  [FIFO_DEPTH];
  logic [PTR_W-1:0] wrPtr;
  logic [PTR_W-1:0] rdPtr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             push;
  logic             pop;

  function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full     = count == CNT_W'(FIFO_DEPTH);
  assign popValid = count != '0;
  assign pop      = popAck & popValid;
  // A pop in the same cycle frees the slot for the push
  assign push     = refStrobe & (~full | pop);

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (push) begin
        wrPtr <= nextPtr(wrPtr);
      end
      if (pop) begin
        rdPtr <= nextPtr(rdPtr);
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
      // Dropped push, sticky until reset
      if (refStrobe && !push) begin
        overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      acRefMem[wrPtr] <= refAcRef;
      writeMem[wrPtr] <= refWrite;
      addrMem[wrPtr]  <= refAddr;
      dataMem[wrPtr]  <= refData;
    end
  end

  assign headAcRef = acRefMem[rdPtr];
  assign headWrite = writeMem[rdPtr];
  assign headAddr  = addrMem[rdPtr];
  assign headData  = dataMem[rdPtr];

endmodule

`default_nettype wire

/* microDecode.sv */
`timescale 1ns/1ns
`default_nettype none

module microDecode import klCtlPkg::*; (
  input  wire logic   clk,
  input  wire logic   arstN,
  input  wire logic   uStrobe,
  input  wire uWord_t uWord,
  output logic        ctlStrobe,
  output vmaSrc_e     vmaSrc,
  output vmaxSel_e    vmaxSel,
  output logic [7:0]  magic,
  output logic        memRead,
  output logic        memWrite,
  output logic        loadPc,
  output logic        loadHeld,
  output logic        loadBreak,
  output logic        loadPrevCtx
);

  vmaSrc_e    srcField;
  vmaxSel_e   vmaxField;
  logic [7:0] magicField;

  // Field decode of the incoming microword
  assign srcField   = vmaSrc_e'(uWord[UW_SRC_LSB +: 2]);
  assign vmaxField  = vmaxSel_e'(uWord[UW_VMAX_LSB +: 2]);
  assign magicField = uWord[UW_MAGIC_LSB +: 8];

  // One cycle of strobes per microword, idle values otherwise
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      ctlStrobe   <= 1'b0;
      vmaSrc      <= SRC_KEEP;
      vmaxSel     <= SEC_KEEP;
      magic       <= '0;
      memRead     <= 1'b0;
      memWrite    <= 1'b0;
      loadPc      <= 1'b0;
      loadHeld    <= 1'b0;
      loadBreak   <= 1'b0;
      loadPrevCtx <= 1'b0;
    end else begin
      ctlStrobe <= uStrobe;
      if (uStrobe) begin
        vmaSrc  <= srcField;
        vmaxSel <= vmaxField;
        magic   <= magicField;
      end else begin
        vmaSrc  <= SRC_KEEP;
        vmaxSel <= SEC_KEEP;
        magic   <= '0;
      end
      memRead     <= uStrobe & uWord[UW_MEM_READ];
      memWrite    <= uStrobe & uWord[UW_MEM_WRITE];
      loadPc      <= uStrobe & uWord[UW_LOAD_PC];
      loadHeld    <= uStrobe & uWord[UW_LOAD_HELD];
      loadBreak   <= uStrobe & uWord[UW_LOAD_BREAK];
      loadPrevCtx <= uStrobe & uWord[UW_LOAD_PREV];
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Build and run the VMA block testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing \
  -f flist.f \
  --top-module tbEboxVma \
  -o tbEboxVma

# A failing check ends in $fatal, so the exit status carries the result
./obj_dir/tbEboxVma

/* vmaRefModel.svh */
`ifndef VMA_REF_MODEL_SVH
`define VMA_REF_MODEL_SVH

// Expected VMA after one control strobe
function automatic vmaAddr_t predictNextVma(
  input vmaAddr_t     vmaNow,
  input vmaAddr_t     pc,
  input logic [13:17] prevSec,
  input adWord_u      adWord,
  input vmaSrc_e      src,
  input vmaxSel_e     sel,
  input logic [7:0]   magic
);
  logic [13:17] sec;
  logic [18:35] off;
  case (src)
    SRC_AD:       off = adWord.addr.offset;
    SRC_PC_MAGIC: off = pc[18:35] + 18'(magic);
    SRC_INC:      off = vmaNow[18:35] + 18'd1;
    default:      off = vmaNow[18:35];
  endcase
  case (sel)
    SEC_PC:   sec = pc[13:17];
    SEC_PREV: sec = prevSec;
    SEC_AD:   sec = adWord.addr.section;
    default:  sec = vmaNow[13:17];
  endcase
  return {sec, off};
endfunction

// Fast AC space is sections 0 and 1 below offset 16
function automatic logic isAcAddr(input vmaAddr_t addr);
  logic [13:17] sec;
  logic [18:35] off;
  sec = addr[13:17];
  off = addr[18:35];
  return (sec == 5'd0 || sec == 5'd1) && off < 18'(AC_COUNT);
endfunction

function automatic ebusWord_t diagWordOf(
  input diagSel_e sel,
  input vmaAddr_t pc,
  input vmaAddr_t held,
  input vmaAddr_t brk,
  input vmaAddr_t vmaNow
);
  case (sel)
    DIAG_PC:    return {13'd0, pc};
    DIAG_HELD:  return {13'd0, held};
    DIAG_BREAK: return {13'd0, brk};
    default:    return {13'd0, vmaNow};
  endcase
endfunction

`endif

/* tbEboxVma.sv */
`timescale 1ns/1ns
`default_nettype none

module tbEboxVma import klWordPkg::*, klCtlPkg::*;;

  `include "vmaRefModel.svh"

  localparam int TIMEOUT_CYCLES = 200;
  // Memory and load bits of the microword from memRead down to loadPrevCtx
  localparam logic [5:0] F_RD   = 6'h20;
  localparam logic [5:0] F_WR   = 6'h10;
  localparam logic [5:0] F_PC   = 6'h08;
  localparam logic [5:0] F_HELD = 6'h04;
  localparam logic [5:0] F_BRK  = 6'h02;
  localparam logic [5:0] F_PREV = 6'h01;

  logic         clk;
  logic         arstN;
  logic         uStrobe;
  uWord_t       uWord;
  adWord_u      ad;
  logic         diagStrobe;
  diagSel_e     diagSel;
  vmaAddr_t     vmaOut;
  vmaAddr_t     pcOut;
  logic         brkMatch;
  logic         diagValid;
  ebusWord_t    diagData;
  logic         acRdValid;
  ebusWord_t    acRdData;
  logic         memReq;
  vmaAddr_t     memAddr;
  logic         memWrite;
  ebusWord_t    memData;
  logic         fifoOverflow;
  integer       seed;
  int           cycle;
  int           i;
  adWord_u      adNext;
  vmaAddr_t     modelVma;
  vmaAddr_t     modelPc;
  vmaAddr_t     modelHeld;
  vmaAddr_t     modelBrk;
  logic [13:17] modelPrev;
  ebusWord_t    modelAc [AC_COUNT];
  int           vmaDue [$];
  vmaAddr_t     vmaExp [$];
  logic         brkExp [$];
  ebusWord_t    acExp [$];
  vmaAddr_t     memAddrExp [$];
  logic         memWriteExp [$];
  ebusWord_t    memDataExp [$];

  eboxVmaTop #(.FIFO_DEPTH(4)) u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    cycle = 0;
    forever begin
      @(posedge clk);
      cycle++;
    end
  end

  task automatic abortRun(input string msg);
    $display("%s", msg);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  task automatic checkAddr(input string name, input vmaAddr_t exp, input vmaAddr_t act);
    if (exp !== act) begin
      abortRun($sformatf("Error at %0t: %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic checkWord(input string name, input ebusWord_t exp, input ebusWord_t act);
    if (exp !== act) begin
      abortRun($sformatf("Error at %0t: %s expected %h actual %h", $time, name, exp, act));
    end
  endtask

  task automatic checkBit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      abortRun($sformatf("Error at %0t: %s expected %b actual %b", $time, name, exp, act));
    end
  endtask

  function automatic uWord_t makeWord(input vmaSrc_e src, input vmaxSel_e sel,
                                      input logic [7:0] mg, input logic [5:0] flags);
    uWord_t w;
    w = '0;
    w[UW_SRC_LSB +: 2]   = src;
    w[UW_VMAX_LSB +: 2]  = sel;
    w[UW_MAGIC_LSB +: 8] = mg;
    w[UW_LOAD_PREV +: 6] = flags;
    return w;
  endfunction

  function automatic adWord_u makeAd(input logic [4:0] sec, input logic [17:0] off);
    adWord_u a;
    a.raw          = '0;
    a.addr.section = sec;
    a.addr.offset  = off;
    return a;
  endfunction

  // Bias keeps the address near the fast AC space
  function automatic adWord_u randomAd(input logic acBias);
    logic [63:0] r;
    adWord_u     a;
    r     = {$random(seed), $random(seed)};
    a.raw = r[35:0];
    if (acBias) begin
      a.addr.section = {3'd0, r[41:40]};
      a.addr.offset  = {13'd0, r[52:48]};
    end
    return a;
  endfunction

  // Advance the model by one microword and queue what the DUT must show
  task automatic modelStep(input uWord_t w, input adWord_u a);
    vmaAddr_t   nextVma;
    logic [3:0] idx;
    nextVma = predictNextVma(modelVma, modelPc, modelPrev, a, vmaSrc_e'(w[UW_SRC_LSB +: 2]),
                             vmaxSel_e'(w[UW_VMAX_LSB +: 2]), w[UW_MAGIC_LSB +: 8]);
    if (w[UW_LOAD_PC]) modelPc = modelVma;
    if (w[UW_LOAD_HELD]) modelHeld = modelVma;
    if (w[UW_LOAD_BREAK]) modelBrk = {a.addr.section, a.addr.offset};
    if (w[UW_LOAD_PREV]) modelPrev = a.addr.section;
    modelVma = nextVma;
    vmaDue.push_back(cycle + 2);
    vmaExp.push_back(nextVma);
    brkExp.push_back(modelBrk == nextVma);
    if (w[UW_MEM_READ] || w[UW_MEM_WRITE]) begin
      idx = nextVma[32:35];
      if (isAcAddr(nextVma) && w[UW_MEM_WRITE]) begin
        modelAc[idx] = a.raw;
      end else if (isAcAddr(nextVma)) begin
        acExp.push_back(modelAc[idx]);
      end else begin
        memAddrExp.push_back(nextVma);
        memWriteExp.push_back(w[UW_MEM_WRITE]);
        memDataExp.push_back(a.raw);
      end
    end
  endtask

  // AD trails its microword by one cycle to meet the control strobes
  task automatic step(input logic strobe, input uWord_t w, input adWord_u a);
    @(posedge clk);
    #10;
    uStrobe = strobe;
    uWord   = w;
    ad      = adNext;
    adNext  = a;
    if (strobe) modelStep(w, a);
  endtask

  task automatic issue(input uWord_t w, input adWord_u a);
    step(1'b1, w, a);
  endtask

  task automatic waitDrained();
    int n;
    step(1'b0, '0, adNext);
    n = 0;
    while ((vmaExp.size() + acExp.size() + memAddrExp.size()) != 0 && n < TIMEOUT_CYCLES) begin
      @(posedge clk);
      n++;
    end
    if (vmaExp.size() != 0) abortRun("A VMA update never showed up on vmaOut");
    if (acExp.size() != 0) abortRun("An expected AC read result never arrived");
    if (memAddrExp.size() != 0) abortRun("An expected memory request never arrived");
  endtask

  task automatic diagCheck(input diagSel_e sel);
    ebusWord_t expWord;
    expWord = diagWordOf(sel, modelPc, modelHeld, modelBrk, modelVma);
    @(posedge clk);
    #10;
    diagStrobe = 1'b1;
    diagSel    = sel;
    @(posedge clk);
    #10;
    diagStrobe = 1'b0;
    // Registered read answers one cycle after the strobe
    checkBit("diagValid", 1'b1, diagValid);
    checkWord("diagData", expWord, diagData);
    @(posedge clk);
    #10;
    checkBit("diagValid", 1'b0, diagValid);
  endtask

  task automatic checkRegs();
    waitDrained();
    checkAddr("pcOut", modelPc, pcOut);
    diagCheck(DIAG_PC);
    diagCheck(DIAG_HELD);
    diagCheck(DIAG_BREAK);
    diagCheck(DIAG_VMA);
  endtask

  // Scoreboard samples outputs mid-cycle
  initial begin
    forever begin
      @(negedge clk);
      if (vmaDue.size() != 0 && vmaDue[0] == cycle) begin
        void'(vmaDue.pop_front());
        checkAddr("vmaOut", vmaExp.pop_front(), vmaOut);
        checkBit("brkMatch", brkExp.pop_front(), brkMatch);
      end
      if (acRdValid) begin
        if (acExp.size() == 0) abortRun("acRdValid pulsed with no AC read outstanding");
        checkWord("acRdData", acExp.pop_front(), acRdData);
      end
      if (memReq) begin
        if (memAddrExp.size() == 0) abortRun("memReq pulsed with no memory reference outstanding");
        checkAddr("memAddr", memAddrExp.pop_front(), memAddr);
        checkBit("memWrite", memWriteExp.pop_front(), memWrite);
        checkWord("memData", memDataExp.pop_front(), memData);
      end
    end
  end

  initial begin
    seed       = 95792;
    arstN      = 1'b0;
    uStrobe    = 1'b0;
    uWord      = '0;
    ad         = '0;
    adNext     = '0;
    diagStrobe = 1'b0;
    diagSel    = DIAG_PC;
    modelVma   = '0;
    modelPc    = '0;
    modelHeld  = '0;
    modelBrk   = '0;
    modelPrev  = '0;
    repeat (3) @(posedge clk);
    #10;
    arstN = 1'b1;

    // Every offset and section source with PC plus magic wrapping past 3FFFF
    issue(makeWord(SRC_AD, SEC_AD, 8'h00, 6'h00), makeAd(5'd3, 18'h3FFF0));
    issue(makeWord(SRC_INC, SEC_KEEP, 8'h00, F_PC | F_HELD), makeAd(5'd9, 18'h0));
    issue(makeWord(SRC_PC_MAGIC, SEC_PC, 8'h20, F_PREV), makeAd(5'd7, 18'h0));
    issue(makeWord(SRC_INC, SEC_PREV, 8'h00, 6'h00), makeAd(5'd0, 18'h0));
    checkRegs();

    // Address break hit then miss
    issue(makeWord(SRC_KEEP, SEC_KEEP, 8'h00, F_BRK), makeAd(5'd5, 18'h00123));
    issue(makeWord(SRC_AD, SEC_AD, 8'h00, 6'h00), makeAd(5'd5, 18'h00123));
    issue(makeWord(SRC_INC, SEC_KEEP, 8'h00, 6'h00), makeAd(5'd0, 18'h0));
    checkRegs();

    // Fill all fast ACs and read them back through the other section
    for (i = 0; i < AC_COUNT; i++) begin
      issue(makeWord(SRC_AD, SEC_AD, 8'h00, 6'h00), makeAd(5'(i % 2), 18'(i)));
      issue(makeWord(SRC_KEEP, SEC_KEEP, 8'h00, F_WR), randomAd(1'b0));
    end
    for (i = AC_COUNT - 1; i >= 0; i--) begin
      issue(makeWord(SRC_AD, SEC_AD, 8'h00, F_RD), makeAd(5'((i + 1) % 2), 18'(i)));
    end
    // Section 2 goes to memory
    for (i = 0; i < 4; i++) begin
      issue(makeWord(SRC_AD, SEC_AD, 8'h00, F_RD), makeAd(5'd2, 18'(i)));
      issue(makeWord(SRC_KEEP, SEC_KEEP, 8'h00, F_WR), randomAd(1'b0));
    end
    waitDrained();

    for (i = 0; i < 60; i++) begin
      if (i % 4 == 3) begin
        step(1'b0, '0, adNext);
      end else begin
        issue(24'($random(seed)), randomAd(i % 2 == 0));
      end
    end
    checkRegs();

    // Five references back to back
    issue(makeWord(SRC_AD, SEC_AD, 8'h00, 6'h00), makeAd(5'd4, 18'h00100));
    for (i = 0; i < 5; i++) begin
      issue(makeWord(SRC_INC, SEC_KEEP, 8'h00, (i % 2 == 1) ? F_WR : F_RD), randomAd(1'b0));
    end
    waitDrained();
    checkBit("fifoOverflow", 1'b0, fifoOverflow);

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* vma.sv */
`timescale 1ns/1ns
`default_nettype none

module vma import klWordPkg::*, klCtlPkg::*; (
  input  wire logic     clk,
  input  wire logic     arstN,
  input  wire logic     ctlStrobe,
  input  wire vmaSrc_e  vmaSrc,
  input  wire vmaxSel_e vmaxSel,
  input  wire logic [7:0] magic,
  input  wire logic     memRead,
  input  wire logic     memWrite,
  input  wire logic     loadPc,
  input  wire logic     loadHeld,
  input  wire logic     loadBreak,
  input  wire logic     loadPrevCtx,
  input  wire adWord_u  ad,
  input  wire logic     diagStrobe,
  input  wire diagSel_e diagSel,
  output vmaAddr_t      vmaOut,
  output vmaAddr_t      pcOut,
  output logic          brkMatch,
  output logic          refStrobe,
  output logic          refAcRef,
  output logic          refWrite,
  output vmaAddr_t      refAddr,
  output ebusWord_t     refData,
  output logic          diagValid,
  output ebusWord_t     diagData
);

  vmaAddr_t     vmaReg;
  vmaAddr_t     pcReg;
  vmaAddr_t     heldReg;
  vmaAddr_t     brkReg;
  logic [13:17] prevSec;
  logic [13:17] nextSec;
  logic [18:35] nextOff;
  logic         acRef;
  logic         refPend;
  logic         pendWrite;
  ebusWord_t    pendData;
  vmaAddr_t     diagSrc;

  // Offset adders wrap at 2^18
  always_comb begin
    case (vmaSrc)
      SRC_AD:       nextOff = ad.addr.offset;
      SRC_PC_MAGIC: nextOff = pcReg[18:35] + 18'(magic);
      SRC_INC:      nextOff = vmaReg[18:35] + 18'd1;
      default:      nextOff = vmaReg[18:35];
    endcase
  end

  always_comb begin
    case (vmaxSel)
      SEC_PC:   nextSec = pcReg[13:17];
      SEC_PREV: nextSec = prevSec;
      SEC_AD:   nextSec = ad.addr.section;
      default:  nextSec = vmaReg[13:17];
    endcase
  end

  // Fast AC space is offsets 0..15 of section 0 or 1
  assign acRef = (vmaReg[13:16] == 4'd0) && (vmaReg[18:35] < 18'(AC_COUNT));

  assign brkMatch = brkReg == vmaReg;
  assign vmaOut   = vmaReg;
  assign pcOut    = pcReg;

  // All loads see the VMA from before this edge
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      vmaReg  <= '0;
      pcReg   <= '0;
      heldReg <= '0;
      brkReg  <= '0;
      prevSec <= '0;
    end else if (ctlStrobe) begin
      vmaReg <= {nextSec, nextOff};
      if (loadPc) begin
        pcReg <= vmaReg;
      end
      if (loadHeld) begin
        heldReg <= vmaReg;
      end
      if (loadBreak) begin
        brkReg <= {ad.addr.section, ad.addr.offset};
      end
      if (loadPrevCtx) begin
        prevSec <= ad.addr.section;
      end
    end
  end

  // Reference leaves once the new VMA is in the register
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      refPend   <= 1'b0;
      refStrobe <= 1'b0;
      diagValid <= 1'b0;
    end else begin
      refPend   <= ctlStrobe & (memRead | memWrite);
      refStrobe <= refPend;
      diagValid <= diagStrobe;
    end
  end

  always_ff @(posedge clk) begin
    if (ctlStrobe) begin
      pendWrite <= memWrite;
      pendData  <= ad.raw;
    end
    if (refPend) begin
      refAddr  <= vmaReg;
      refAcRef <= acRef;
      refWrite <= pendWrite;
      refData  <= pendData;
    end
  end

  always_comb begin
    case (diagSel)
      DIAG_PC:    diagSrc = pcReg;
      DIAG_HELD:  diagSrc = heldReg;
      DIAG_BREAK: diagSrc = brkReg;
      default:    diagSrc = vmaReg;
    endcase
  end

  // Zero-extended into the low 23 bits
  always_ff @(posedge clk) begin
    if (diagStrobe) begin
      diagData <= {13'd0, diagSrc};
    end
  end

endmodule

`default_nettype wire
